//--- hdl/policer_config.svh
// build-time constants for the ingress policer.
// port count, field widths and the legal frame length window.

`ifndef POLICER_CONFIG_SVH
`define POLICER_CONFIG_SVH

// ----------------------------------------------------------------------
// ports and beat fields
// ----------------------------------------------------------------------

`define POL_NUM_PORTS   4      // ingress ports policed.
`define POL_LEN_BITS    12     // packet byte length field.
`define POL_TAG_BITS    16     // opaque packet tag.

// ----------------------------------------------------------------------
// token bucket fixed point format
// ----------------------------------------------------------------------

// bucket fill is whole.fraction bytes.
`define POL_WHOLE_BITS  16
`define POL_FRAC_BITS   4      // drain resolution is 1/16 byte per cycle.

// ----------------------------------------------------------------------
// length screen and statistics
// ----------------------------------------------------------------------

`define POL_MTU_BYTES   2000   // longest legal packet.
`define POL_MIN_BYTES   64     // shortest legal frame.
`define POL_CNT_BITS    16     // saturating drop counters.

`endif

//--- hdl/policer_pkg.sv
// shared types of the ingress policer.
// beat fields, token bucket format and drop counters.

`include "policer_config.svh"

package policer_pkg;

    // ------------------------------------------------------------------
    // metadata beat fields
    // ------------------------------------------------------------------

    // index of the ingress port a packet arrived on.
    typedef logic [$clog2(`POL_NUM_PORTS)-1:0] port_t;

    typedef logic [`POL_LEN_BITS-1:0] byte_len_t;   // packet length in bytes.

    // carried through untouched so the beat can be matched downstream.
    typedef logic [`POL_TAG_BITS-1:0] pkt_tag_t;

    // ------------------------------------------------------------------
    // token bucket
    // ------------------------------------------------------------------

    // fill level in bytes, fixed point.
    typedef struct packed {
        logic [`POL_WHOLE_BITS-1:0] whole;     // integer bytes.
        logic [`POL_FRAC_BITS-1:0]  fraction;  // sub-byte remainder.
    } bucket_t;

    // per-cycle drain, same layout as the fill level so the two subtract directly.
    typedef bucket_t bucket_decrement_t;

    // bucket limit, compared against the whole part only.
    typedef logic [`POL_WHOLE_BITS-1:0] bucket_depth_threshold_t;

    // ------------------------------------------------------------------
    // statistics
    // ------------------------------------------------------------------

    typedef logic [`POL_CNT_BITS-1:0] drop_cnt_t;   // sticks at all ones.

endpackage

//--- hdl/rate_policer.sv
// per-port token bucket rate policer.
// marks a beat one cycle later when it would overfill its port's bucket.

`timescale 1ns/100ps
`include "policer_config.svh"

module rate_policer
    import policer_pkg::*;
(
    input  logic                    packet_in,
    input  logic                    arst_n,

    input  logic                    pkt_valid,
    input  port_t                   ingress_port,
    input  byte_len_t               byte_length,

    input  logic [`POL_NUM_PORTS-1:0] policer_enable,
    input  bucket_decrement_t       bucket_decrement       [`POL_NUM_PORTS-1:0],
    input  bucket_depth_threshold_t bucket_depth_threshold [`POL_NUM_PORTS-1:0],

    output logic                    rate_drop
);

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------

    localparam int NUM_PORTS  = `POL_NUM_PORTS;
    localparam int WHOLE_BITS = `POL_WHOLE_BITS;
    localparam int FRAC_BITS  = `POL_FRAC_BITS;
    localparam int BKT_BITS   = WHOLE_BITS + FRAC_BITS;
    localparam int ACC_BITS   = BKT_BITS + 1;     // one carry bit for fill + length.
    localparam int CMP_BITS   = WHOLE_BITS + 1;   // threshold compare with carry.

    // ------------------------------------------------------------------
    // state
    // ------------------------------------------------------------------

    bucket_t              bucket_q [NUM_PORTS-1:0];
    bucket_t              bucket_d [NUM_PORTS-1:0];
    logic [NUM_PORTS-1:0] port_hit;     // beat addressed to this port.
    logic [NUM_PORTS-1:0] port_over;    // beat would exceed the threshold.
    logic [ACC_BITS-1:0]  fill;         // packet length in bucket units.

    // adds a fill amount, then drains, flooring the result at zero.
    function automatic bucket_t fill_and_drain(
        input bucket_t             level,
        input logic [ACC_BITS-1:0] add,
        input bucket_decrement_t   drain
    );
        logic [ACC_BITS-1:0] total;
        logic [ACC_BITS-1:0] sub;
        logic [ACC_BITS-1:0] diff;
        total = {1'b0, level} + add;
        sub   = {1'b0, drain};
        diff  = total - sub;
        if (total > sub) begin
            fill_and_drain = bucket_t'(diff[BKT_BITS-1:0]);
        end else begin
            fill_and_drain = '0;
        end
    endfunction

    // length moves into the whole part of the bucket.
    assign fill = ACC_BITS'({byte_length, {FRAC_BITS{1'b0}}});

    // ------------------------------------------------------------------
    // bucket update, all ports in parallel
    // ------------------------------------------------------------------

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            port_hit[p]  = pkt_valid && (ingress_port == port_t'(p));
            port_over[p] = ({1'b0, bucket_q[p].whole} + CMP_BITS'(byte_length))
                           > {1'b0, bucket_depth_threshold[p]};

            if (!policer_enable[p]) begin
                bucket_d[p] = '0;                  // disabled port holds no tokens.
            end else if (port_hit[p] && !port_over[p]) begin
                bucket_d[p] = fill_and_drain(bucket_q[p], fill, bucket_decrement[p]);
            end else begin
                // idle or over the limit, drain only.
                bucket_d[p] = fill_and_drain(bucket_q[p], '0, bucket_decrement[p]);
            end
        end
    end

    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            bucket_q  <= '{default: '0};
            rate_drop <= 1'b0;
        end else begin
            bucket_q  <= bucket_d;
            rate_drop <= |(port_hit & port_over & policer_enable);   // at most one hit.
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port_chk
        // a port that is switched off starts from an empty bucket.
        a_disabled_empty: assert property (
            @(posedge packet_in) disable iff (!arst_n)
            !policer_enable[p] |=> (bucket_q[p] == '0)
        );
    end

endmodule

//--- hdl/length_screen.sv
// length screen against the MTU and minimum frame size.
// also carries the beat fields one cycle, aligned with the rate mark.

`timescale 1ns/100ps
`include "policer_config.svh"

module length_screen
    import policer_pkg::*;
(
    input  logic      packet_in,
    input  logic      arst_n,

    input  logic      pkt_valid,
    input  port_t     ingress_port,
    input  byte_len_t byte_length,
    input  pkt_tag_t  pkt_tag,

    output logic      len_valid,
    output logic      len_drop,
    output port_t     len_port,
    output byte_len_t len_length,
    output pkt_tag_t  len_tag
);

    // ------------------------------------------------------------------
    // legal length window
    // ------------------------------------------------------------------

    localparam byte_len_t MTU_LEN = byte_len_t'(`POL_MTU_BYTES);
    localparam byte_len_t MIN_LEN = byte_len_t'(`POL_MIN_BYTES);

    logic bad_length;

    // both bounds are inclusive.
    assign bad_length = (byte_length > MTU_LEN) || (byte_length < MIN_LEN);

    // ------------------------------------------------------------------
    // registered verdict
    // ------------------------------------------------------------------

    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            len_valid <= 1'b0;
            len_drop  <= 1'b0;
        end else begin
            len_valid <= pkt_valid;
            len_drop  <= pkt_valid && bad_length;   // only a real beat is marked.
        end
    end

    // beat fields, loaded only on a valid beat.
    always_ff @(posedge packet_in) begin
        if (pkt_valid) begin
            len_port   <= ingress_port;
            len_length <= byte_length;
            len_tag    <= pkt_tag;
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------

    a_drop_has_beat: assert property (
        @(posedge packet_in) disable iff (!arst_n)
        len_drop |-> len_valid
    );

endmodule

//--- hdl/drop_marker.sv
// joins the rate and length verdicts into the marked output beat.
// keeps one saturating drop counter per reason.

`timescale 1ns/100ps

module drop_marker
    import policer_pkg::*;
(
    input  logic      packet_in,
    input  logic      arst_n,

    // aligned beat from the length screen.
    input  logic      len_valid,
    input  logic      len_drop,
    input  port_t     len_port,
    input  byte_len_t len_length,
    input  pkt_tag_t  len_tag,

    // mark from the rate policer, same cycle.
    input  logic      rate_drop,

    output logic      out_valid,
    output port_t     out_port,
    output byte_len_t out_length,
    output pkt_tag_t  out_tag,
    output logic      out_drop_rate,
    output logic      out_drop_length,
    output logic      out_drop,
    output drop_cnt_t drop_cnt_rate,
    output drop_cnt_t drop_cnt_length
);

    // ------------------------------------------------------------------
    // output beat
    // ------------------------------------------------------------------

    assign out_valid       = len_valid;
    assign out_port        = len_port;
    assign out_length      = len_length;
    assign out_tag         = len_tag;
    assign out_drop_rate   = rate_drop;
    assign out_drop_length = len_drop;
    assign out_drop        = rate_drop || len_drop;    // either reason drops.

    // ------------------------------------------------------------------
    // drop statistics
    // ------------------------------------------------------------------

    logic rate_inc;
    logic length_inc;

    // a full counter stays put.
    assign rate_inc   = out_valid && out_drop_rate   && (drop_cnt_rate   != '1);
    assign length_inc = out_valid && out_drop_length && (drop_cnt_length != '1);

    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            drop_cnt_rate   <= '0;
            drop_cnt_length <= '0;
        end else begin
            if (rate_inc) begin
                drop_cnt_rate <= drop_cnt_rate + 1'b1;
            end
            if (length_inc) begin
                drop_cnt_length <= drop_cnt_length + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------

    // the rate mark must line up with the beat delayed by the length screen.
    a_rate_mark_aligned: assert property (
        @(posedge packet_in) disable iff (!arst_n)
        out_drop_rate |-> out_valid
    );

endmodule

//--- hdl/ingress_policer.sv
// top level of the ingress policer.
// rate policer and length screen in parallel, joined by the drop marker.

`timescale 1ns/100ps
`include "policer_config.svh"

module ingress_policer
    import policer_pkg::*;
(
    input  logic                    packet_in,
    input  logic                    arst_n,

    // input metadata beat.
    input  logic                    pkt_valid,
    input  port_t                   ingress_port,
    input  byte_len_t               byte_length,
    input  pkt_tag_t                pkt_tag,

    // quasi-static configuration.
    input  logic [`POL_NUM_PORTS-1:0] policer_enable,
    input  bucket_decrement_t       bucket_decrement       [`POL_NUM_PORTS-1:0],
    input  bucket_depth_threshold_t bucket_depth_threshold [`POL_NUM_PORTS-1:0],

    // marked output beat, one cycle behind the input.
    output logic                    out_valid,
    output port_t                   out_port,
    output byte_len_t               out_length,
    output pkt_tag_t                out_tag,
    output logic                    out_drop_rate,
    output logic                    out_drop_length,
    output logic                    out_drop,
    output drop_cnt_t               drop_cnt_rate,
    output drop_cnt_t               drop_cnt_length
);

    // ------------------------------------------------------------------
    // verdicts, both one cycle behind the input beat
    // ------------------------------------------------------------------

    logic      rate_drop;
    logic      len_valid;
    logic      len_drop;
    port_t     len_port;
    byte_len_t len_length;
    pkt_tag_t  len_tag;

    rate_policer u_rate_policer (
        .packet_in              (packet_in),
        .arst_n                 (arst_n),
        .pkt_valid              (pkt_valid),
        .ingress_port           (ingress_port),
        .byte_length            (byte_length),
        .policer_enable         (policer_enable),
        .bucket_decrement       (bucket_decrement),
        .bucket_depth_threshold (bucket_depth_threshold),
        .rate_drop              (rate_drop)
    );

    length_screen u_length_screen (
        .packet_in    (packet_in),
        .arst_n       (arst_n),
        .pkt_valid    (pkt_valid),
        .ingress_port (ingress_port),
        .byte_length  (byte_length),
        .pkt_tag      (pkt_tag),
        .len_valid    (len_valid),
        .len_drop     (len_drop),
        .len_port     (len_port),
        .len_length   (len_length),
        .len_tag      (len_tag)
    );

    drop_marker u_drop_marker (
        .packet_in       (packet_in),
        .arst_n          (arst_n),
        .len_valid       (len_valid),
        .len_drop        (len_drop),
        .len_port        (len_port),
        .len_length      (len_length),
        .len_tag         (len_tag),
        .rate_drop       (rate_drop),
        .out_valid       (out_valid),
        .out_port        (out_port),
        .out_length      (out_length),
        .out_tag         (out_tag),
        .out_drop_rate   (out_drop_rate),
        .out_drop_length (out_drop_length),
        .out_drop        (out_drop),
        .drop_cnt_rate   (drop_cnt_rate),
        .drop_cnt_length (drop_cnt_length)
    );

endmodule

//--- tests/clk_rst_gen.sv
// clock and power-on reset for the ingress policer testbench.

`timescale 1ns/100ps

module clk_rst_gen (
    output logic packet_in,
    output logic arst_n,
    input  logic rst_req      // extra reset from the test sequence.
);

    localparam real HALF_PERIOD  = 2.0;   // 4 ns clock.
    localparam int  RESET_CYCLES = 8;

    logic por_n;

    initial begin
        packet_in = 1'b0;
        forever #(HALF_PERIOD) packet_in = ~packet_in;
    end

    // release a little after an edge.
    initial begin
        por_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge packet_in);
        #1;
        por_n = 1'b1;
    end

    assign arst_n = por_n && !rst_req;

endmodule

//--- tests/ingress_policer_tb.sv
// testbench for the ingress policer.
// reference bucket model, output assertions and five directed tests.

`timescale 1ns/100ps
`include "policer_config.svh"

module ingress_policer_tb
    import policer_pkg::*;
();

    localparam int NUM_PORTS = `POL_NUM_PORTS;
    localparam int SCALE     = 1 << `POL_FRAC_BITS;   // bucket units per byte.
    localparam int MTU       = `POL_MTU_BYTES;
    localparam int MIN       = `POL_MIN_BYTES;
    localparam int BURST_THR = 1000;
    localparam int BURST_LEN = 300;

    logic                    packet_in;
    logic                    arst_n;
    logic                    rst_req;
    logic                    pkt_valid;
    port_t                   ingress_port;
    byte_len_t               byte_length;
    pkt_tag_t                pkt_tag;
    logic [NUM_PORTS-1:0]    policer_enable;
    bucket_decrement_t       bucket_decrement       [NUM_PORTS-1:0];
    bucket_depth_threshold_t bucket_depth_threshold [NUM_PORTS-1:0];
    logic                    out_valid;
    port_t                   out_port;
    byte_len_t               out_length;
    pkt_tag_t                out_tag;
    logic                    out_drop_rate;
    logic                    out_drop_length;
    logic                    out_drop;
    drop_cnt_t               drop_cnt_rate;
    drop_cnt_t               drop_cnt_length;

    clk_rst_gen u_clk_rst (.packet_in(packet_in), .arst_n(arst_n), .rst_req(rst_req));

    ingress_policer UUT (
        .packet_in(packet_in), .arst_n(arst_n),
        .pkt_valid(pkt_valid), .ingress_port(ingress_port),
        .byte_length(byte_length), .pkt_tag(pkt_tag),
        .policer_enable(policer_enable), .bucket_decrement(bucket_decrement),
        .bucket_depth_threshold(bucket_depth_threshold),
        .out_valid(out_valid), .out_port(out_port), .out_length(out_length),
        .out_tag(out_tag), .out_drop_rate(out_drop_rate),
        .out_drop_length(out_drop_length), .out_drop(out_drop),
        .drop_cnt_rate(drop_cnt_rate), .drop_cnt_length(drop_cnt_length)
    );

    // ----------------------------------------------------------------------
    // reference model of the expected output beat
    // ----------------------------------------------------------------------

    logic      exp_valid, exp_drop_rate, exp_drop_length;
    port_t     exp_port;
    byte_len_t exp_length;
    pkt_tag_t  exp_tag;
    drop_cnt_t exp_cnt_rate, exp_cnt_length;
    int        model_bkt [NUM_PORTS];    // fill in 1/SCALE byte units.
    int        in_count, out_count, rate_pass_cnt;
    int        errors, n_tests, n_failed, test_err_start;

    always @(posedge packet_in or negedge arst_n) begin
        int  next_fill;
        int  drain;
        logic mark;
        if (!arst_n) begin
            exp_valid       <= 1'b0;
            exp_drop_rate   <= 1'b0;
            exp_drop_length <= 1'b0;
            exp_cnt_rate    <= '0;
            exp_cnt_length  <= '0;
            for (int p = 0; p < NUM_PORTS; p++) model_bkt[p] = 0;
        end else begin
            // counters move on the edge after the marked beat.
            if (exp_valid && exp_drop_rate && exp_cnt_rate != '1)
                exp_cnt_rate <= exp_cnt_rate + 16'd1;
            if (exp_valid && exp_drop_length && exp_cnt_length != '1)
                exp_cnt_length <= exp_cnt_length + 16'd1;
            exp_valid       <= pkt_valid;
            exp_port        <= ingress_port;
            exp_length      <= byte_length;
            exp_tag         <= pkt_tag;
            exp_drop_length <= pkt_valid && (byte_length > MTU || byte_length < MIN);
            if (pkt_valid) in_count++;
            mark = 1'b0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                drain     = bucket_decrement[p].whole * SCALE + bucket_decrement[p].fraction;
                next_fill = model_bkt[p] - drain;
                if (pkt_valid && ingress_port == p) begin
                    if (model_bkt[p] / SCALE + byte_length > bucket_depth_threshold[p])
                        mark = policer_enable[p];
                    else
                        next_fill += byte_length * SCALE;
                end
                if (!policer_enable[p]) model_bkt[p] = 0;
                else model_bkt[p] = (next_fill < 0) ? 0 : next_fill;
            end
            exp_drop_rate <= mark;
        end
    end

    always @(posedge packet_in) begin
        if (out_valid) begin
            out_count++;
            if (!out_drop_rate) rate_pass_cnt++;
        end
    end

    // ----------------------------------------------------------------------
    // output checks
    // ----------------------------------------------------------------------

    task automatic report_mismatch(input string name, input longint expv, input longint got);
        $display("[ERROR] %0t ns %s expected %0d got %0d", $time, name, expv, got);
        errors++;
    endtask

    a_valid: assert property (@(posedge packet_in) disable iff (!arst_n)
        out_valid == exp_valid)
        else report_mismatch("out_valid", $sampled(exp_valid), $sampled(out_valid));
    a_port: assert property (@(posedge packet_in) disable iff (!arst_n)
        exp_valid |-> out_port == exp_port)
        else report_mismatch("out_port", $sampled(exp_port), $sampled(out_port));
    a_length: assert property (@(posedge packet_in) disable iff (!arst_n)
        exp_valid |-> out_length == exp_length)
        else report_mismatch("out_length", $sampled(exp_length), $sampled(out_length));
    a_tag: assert property (@(posedge packet_in) disable iff (!arst_n)
        exp_valid |-> out_tag == exp_tag)
        else report_mismatch("out_tag", $sampled(exp_tag), $sampled(out_tag));
    a_drop_rate: assert property (@(posedge packet_in) disable iff (!arst_n)
        out_drop_rate == exp_drop_rate)
        else report_mismatch("out_drop_rate", $sampled(exp_drop_rate), $sampled(out_drop_rate));
    a_drop_length: assert property (@(posedge packet_in) disable iff (!arst_n)
        out_drop_length == exp_drop_length)
        else report_mismatch("out_drop_length", $sampled(exp_drop_length),
                             $sampled(out_drop_length));
    a_drop: assert property (@(posedge packet_in) disable iff (!arst_n)
        out_drop == (exp_drop_rate || exp_drop_length))
        else report_mismatch("out_drop", $sampled(exp_drop_rate || exp_drop_length),
                             $sampled(out_drop));
    a_cnt_rate: assert property (@(posedge packet_in) disable iff (!arst_n)
        drop_cnt_rate == exp_cnt_rate)
        else report_mismatch("drop_cnt_rate", $sampled(exp_cnt_rate), $sampled(drop_cnt_rate));
    a_cnt_length: assert property (@(posedge packet_in) disable iff (!arst_n)
        drop_cnt_length == exp_cnt_length)
        else report_mismatch("drop_cnt_length", $sampled(exp_cnt_length),
                             $sampled(drop_cnt_length));
    a_reset_clear: assert property (@(posedge packet_in)
        !arst_n |-> (!out_valid && drop_cnt_rate == '0 && drop_cnt_length == '0))
        else begin
            $display("%0t ns: out_valid or a drop counter is not cleared during reset", $time);
            errors++;
        end

    // ----------------------------------------------------------------------
    // stimulus helpers, all driven 1 ns after the rising edge
    // ----------------------------------------------------------------------

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge packet_in);
            #1;
        end
    endtask

    task automatic send_beat(input int port, input int len);
        pkt_valid    = 1'b1;
        ingress_port = port_t'(port);
        byte_length  = byte_len_t'(len);
        pkt_tag      = pkt_tag_t'($urandom);
        idle(1);
        pkt_valid    = 1'b0;
    endtask

    task automatic wait_reset_release();
        int n;
        for (n = 0; n < 50 && !arst_n; n++) idle(1);
        if (!arst_n) begin
            $display("%0t ns: reset was not released in time", $time);
            errors++;
        end
        idle(1);
    endtask

    task automatic wait_drained();
        int n;
        for (n = 0; n < 20 && out_count != in_count; n++) idle(1);
        if (out_count != in_count) begin
            $display("%0t ns: %0d input beats gave %0d output beats", $time, in_count,
                     out_count);
            errors++;
        end
    endtask

    // waits until the model says a beat of len bytes fits the bucket.
    task automatic wait_bucket_room(input int port, input int len);
        int n;
        for (n = 0; n < 2000 && model_bkt[port] / SCALE + len > bucket_depth_threshold[port];
             n++) idle(1);
        if (n == 2000) begin
            $display("%0t ns: bucket of port %0d never drained", $time, port);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        int delta;
        delta = errors - test_err_start;
        n_tests++;
        if (delta != 0) n_failed++;
        $display("test %0d %-26s %s (%0d errors)", n_tests, name,
                 (delta == 0) ? "ok" : "FAILED", delta);
        test_err_start = errors;
    endtask

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------

    initial begin
        int pass_start;
        void'($urandom(80549));
        rst_req        = 1'b0;
        pkt_valid      = 1'b0;
        ingress_port   = '0;
        byte_length    = '0;
        pkt_tag        = '0;
        policer_enable = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            bucket_decrement[p]       = '0;
            bucket_depth_threshold[p] = '0;
        end
        wait_reset_release();

        // random legal beats, all ports disabled.
        for (int i = 0; i < 40; i++) begin
            send_beat($urandom_range(NUM_PORTS - 1, 0), $urandom_range(MTU, MIN));
            idle($urandom_range(2, 0));
        end
        wait_drained();
        end_test("latency and pass-through");

        send_beat(0, MIN - 1);
        send_beat(0, MIN);
        send_beat(0, MTU);
        send_beat(0, MTU + 1);
        wait_drained();
        end_test("length screen");

        policer_enable[1] = 1'b1;
        policer_enable[2] = 1'b1;
        bucket_depth_threshold[1] = BURST_THR;
        bucket_depth_threshold[2] = BURST_THR;
        pass_start = rate_pass_cnt;
        repeat (BURST_THR / BURST_LEN + 3) send_beat(1, BURST_LEN);
        wait_drained();
        a_burst_count: assert (rate_pass_cnt - pass_start == BURST_THR / BURST_LEN)
            else report_mismatch("passed beats", BURST_THR / BURST_LEN,
                                 rate_pass_cnt - pass_start);
        send_beat(2, BURST_LEN);    // neighbour port keeps its own bucket.
        send_beat(2, BURST_LEN);
        wait_drained();
        end_test("burst against threshold");

        policer_enable[3]         = 1'b1;
        bucket_decrement[3]       = {16'd1, 4'd8};   // 1.5 bytes per cycle.
        bucket_depth_threshold[3] = 600;
        repeat (5) send_beat(3, 200);
        wait_bucket_room(3, 200);
        send_beat(3, 200);
        repeat (4) send_beat(3, 200);
        policer_enable[3] = 1'b0;
        idle(2);
        policer_enable[3] = 1'b1;
        send_beat(3, 600);          // fits only an emptied bucket.
        wait_drained();
        end_test("drain and refill");

        send_beat(0, MIN - 1);
        send_beat(1, BURST_LEN);
        send_beat(1, MTU + 1);      // over the rate and the MTU.
        send_beat(2, 100);
        send_beat(0, 4095);
        wait_drained();
        rst_req = 1'b1;
        idle(3);
        rst_req = 1'b0;
        wait_reset_release();
        send_beat(2, 100);
        wait_drained();
        end_test("counters and reset");

        $display("tests run %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #50000;
        $display("watchdog expired before the test sequence ended");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- ingress_policer.f
+incdir+hdl
hdl/policer_pkg.sv
hdl/rate_policer.sv
hdl/length_screen.sv
hdl/drop_marker.sv
hdl/ingress_policer.sv
tests/clk_rst_gen.sv
tests/ingress_policer_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the ingress policer testbench with Verilator and runs it.
# The run fails when the log holds the fail message.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module ingress_policer_tb \
    -Mdir obj_dir \
    -f ingress_policer.f

./obj_dir/Vingress_policer_tb | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "run_sim: testbench reported failure"
    exit 1
fi

echo "run_sim: done"
exit 0
